// File: all.f
+incdir+hw
hw/spi_reg_pkg.sv
hw/spi_xfer_pkg.sv
hw/spi_cmd_if.sv
hw/spi_fifo.sv
hw/spi_sck_gen.sv
hw/spi_shift_engine.sv
hw/spi_regs.sv
hw/spi_ctrl_top.sv
testbench/spi_slave_model.sv
testbench/spi_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= spi_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/spi_patterns.mem
// Columns: control word, TX word, MISO word driven by the slave
// TX rows leave the MISO column at zero and RX rows the TX column
00280004 a5c30f1e 00000000
00240004 3c96e718 00000000
002e0006 0badf00d 00000000
002a0004 80000001 00000000
002d0008 deadbeef 00000000
00290004 12345678 00000000
002f0006 f0e1d2c3 00000000
002b0004 6b3a0954 00000000
001c0004 00000000 c001d00d
001a0006 00000000 5a5aa5a5
001d0004 00000000 7e3f1c08
001b0008 00000000 96c3e12b

// File: testbench/spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_tb;

    localparam int NPAT       = 12;
    localparam int POLL_LIMIT = 4000;

    logic        clk;
    logic        rstn;
    logic        bus_req;
    logic        bus_we;
    logic [1:0]  bus_addr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        bus_rvalid;
    logic        sck;
    logic        mosi;
    logic        csn;
    logic        miso;
    logic        slv_cpol;
    logic        slv_cpha;
    logic        slv_msb;
    logic [31:0] slv_word;
    logic [31:0] pat_mem [3*NPAT];
    logic [31:0] lfsr_q;
    int          err_cnt;
    int          timeout_cnt;

    spi_ctrl_top dut (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .bus_req_i    (bus_req),
        .bus_we_i     (bus_we),
        .bus_addr_i   (bus_addr),
        .bus_wdata_i  (bus_wdata),
        .bus_rdata_o  (bus_rdata),
        .bus_rvalid_o (bus_rvalid),
        .spi_sck_o    (sck),
        .spi_mosi_o   (mosi),
        .spi_csn_o    (csn),
        .spi_miso_i   (miso)
    );

    spi_slave_model u_slave (
        .sck_i       (sck),
        .csn_i       (csn),
        .mosi_i      (mosi),
        .cpol_i      (slv_cpol),
        .cpha_i      (slv_cpha),
        .msb_first_i (slv_msb),
        .miso_word_i (slv_word),
        .miso_o      (miso)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        err_cnt++;
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    // Bit k on the wire for a word sent in the given order
    function automatic logic wire_bit_of(input logic [31:0] w, input logic msb, input int k);
        return msb ? w[31-k] : w[k];
    endfunction

    task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        bus_req   = 1'b1;
        bus_we    = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(negedge clk);
        bus_req = 1'b0;
        bus_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
        @(negedge clk);
        if (bus_rvalid !== 1'b0) report_mismatch("rvalid before request", 32'(bus_rvalid), 0);
        bus_req  = 1'b1;
        bus_we   = 1'b0;
        bus_addr = addr;
        @(negedge clk);
        bus_req = 1'b0;
        if (bus_rvalid !== 1'b1) begin
            report_mismatch("rvalid one cycle after request", 32'(bus_rvalid), 1);
        end
        data = bus_rdata;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic        done;
        done = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !done; n++) begin
            bus_read(`SPI_REG_STATUS, st);
            done = !st[2];
        end
        if (!done) begin
            $display("timeout at %0t ns: the controller never went idle", $time);
            timeout_cnt++;
        end
    endtask

    task automatic wait_rsp_level(input int target);
        logic [31:0] st;
        logic        done;
        done = 1'b0;
        for (int n = 0; n < POLL_LIMIT && !done; n++) begin
            bus_read(`SPI_REG_STATUS, st);
            done = (int'(st[15:8]) == target);
        end
        if (!done) begin
            $display("timeout at %0t ns: response FIFO level never reached %0d", $time, target);
            timeout_cnt++;
        end
    endtask

    task automatic check_tx_bits(input int start, input logic [31:0] w, input logic msb);
        logic bad;
        bad = 1'b0;
        for (int k = 0; k < 32; k++) begin
            if (u_slave.rec_bits[start+k] !== wire_bit_of(w, msb, k)) bad = 1'b1;
        end
        if (bad) report_mismatch("MOSI bit sequence for word", 32'(start / 32), w);
    endtask

    // Leaves SCK at the new idle level before the slave starts counting edges
    task automatic set_mode(input logic [31:0] ctrl);
        @(negedge clk);
        slv_cpol = ctrl[16];
        slv_cpha = ctrl[17];
        slv_msb  = ctrl[18];
        bus_write(`SPI_REG_CTRL, ctrl & ~32'h0030_0000);
        bus_write(`SPI_REG_TXDATA, 32'h0);
        wait_idle();
        bus_write(`SPI_REG_CTRL, ctrl);
    endtask

    task automatic run_pattern(input int p);
        logic [31:0] ctrl;
        logic [31:0] tx;
        logic [31:0] mw;
        logic [31:0] rd;
        int          start;
        ctrl = pat_mem[3*p];
        tx   = pat_mem[3*p+1];
        mw   = pat_mem[3*p+2];
        slv_word = mw;
        set_mode(ctrl);
        bus_read(`SPI_REG_CTRL, rd);
        if (rd !== ctrl) report_mismatch("CTRL readback", rd, ctrl);
        start = u_slave.rec_cnt;
        bus_write(`SPI_REG_TXDATA, tx);
        if (ctrl[21]) begin
            wait_idle();
            if (u_slave.rec_cnt != start + 32) begin
                report_mismatch("sampled bit count", 32'(u_slave.rec_cnt - start), 32);
            end
            check_tx_bits(start, tx, ctrl[18]);
        end else begin
            wait_rsp_level(1);
            bus_read(`SPI_REG_RXDATA, rd);
            if (rd !== mw) report_mismatch("RXDATA", rd, mw);
        end
        if (csn !== ctrl[19]) report_mismatch("CSN after transfer", 32'(csn), 32'(ctrl[19]));
        if (sck !== ctrl[16]) report_mismatch("SCK rest level", 32'(sck), 32'(ctrl[16]));
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] words [8];
        int          n;
        int          start;
        logic        full_seen;
        logic        keep_csn;
        logic        keep_sck;
        clk = 1'b0;
        rstn = 1'b0;
        bus_req = 1'b0;
        bus_we = 1'b0;
        bus_addr = 2'd0;
        bus_wdata = '0;
        slv_cpol = 1'b0;
        slv_cpha = 1'b0;
        slv_msb = 1'b0;
        slv_word = '0;
        lfsr_q = 32'ha7924fd2;
        err_cnt = 0;
        timeout_cnt = 0;
        $readmemh("testbench/spi_patterns.mem", pat_mem);
        if ((^pat_mem[0]) === 1'bx) begin
            $display("could not read the pattern file");
            err_cnt++;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        if (csn !== 1'b1 || sck !== 1'b0 || mosi !== 1'b0 || bus_rvalid !== 1'b0) begin
            report_mismatch("pins after reset {csn,sck,mosi,rvalid}",
                            32'({csn, sck, mosi, bus_rvalid}), 32'h8);
        end
        bus_read(`SPI_REG_STATUS, rd);
        if (rd !== 32'h2) report_mismatch("STATUS after reset", rd, 32'h2);
        bus_read(`SPI_REG_CTRL, rd);
        if (rd !== 32'h0) report_mismatch("CTRL after reset", rd, 32'h0);

        for (int p = 0; p < NPAT; p++) begin
            run_pattern(p);
        end

        // Fill the command FIFO behind a running transfer, then overrun it
        set_mode(32'h0028_0004);
        start = u_slave.rec_cnt;
        n = 0;
        full_seen = 1'b0;
        while (n < `SPI_CMD_DEPTH + 2 && !full_seen) begin
            words[n] = lfsr_word();
            bus_write(`SPI_REG_TXDATA, words[n]);
            n++;
            bus_read(`SPI_REG_STATUS, rd);
            full_seen = rd[0];
        end
        if (!full_seen) begin
            $display("the command FIFO never reported full");
            err_cnt++;
        end
        bus_write(`SPI_REG_TXDATA, lfsr_word());
        wait_idle();
        if (u_slave.rec_cnt != start + 32*n) begin
            report_mismatch("sampled bits after overrun", 32'(u_slave.rec_cnt - start),
                            32'(32*n));
        end
        for (int i = 0; i < n; i++) begin
            check_tx_bits(start + 32*i, words[i], 1'b0);
        end

        // Queued RX responses, each from a new MISO word
        set_mode(32'h0018_0004);
        for (int i = 0; i < 3; i++) begin
            words[i] = lfsr_word();
            @(negedge clk);
            slv_word = words[i];
            bus_write(`SPI_REG_TXDATA, 32'h0);
            wait_rsp_level(i + 1);
        end
        for (int i = 0; i < 3; i++) begin
            bus_read(`SPI_REG_RXDATA, rd);
            if (rd !== words[i]) report_mismatch("RXDATA in order", rd, words[i]);
        end
        bus_read(`SPI_REG_RXDATA, rd);
        if (rd !== 32'h0) report_mismatch("RXDATA when empty", rd, 32'h0);

        // DIR_NONE touches no pin and pushes nothing
        keep_csn = csn;
        keep_sck = sck;
        start = u_slave.rec_cnt;
        bus_write(`SPI_REG_CTRL, 32'h0000_0004);
        bus_write(`SPI_REG_TXDATA, 32'h1234_5678);
        wait_idle();
        if (csn !== keep_csn) report_mismatch("CSN after DIR_NONE", 32'(csn), 32'(keep_csn));
        if (sck !== keep_sck) report_mismatch("SCK after DIR_NONE", 32'(sck), 32'(keep_sck));
        if (u_slave.rec_cnt != start) begin
            report_mismatch("edges during DIR_NONE", 32'(u_slave.rec_cnt - start), 0);
        end
        bus_read(`SPI_REG_STATUS, rd);
        if (rd !== 32'h2) report_mismatch("STATUS after DIR_NONE", rd, 32'h2);

        $display("errors %0d timeouts %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
    input  wire        sck_i,
    input  wire        csn_i,
    input  wire        mosi_i,
    input  wire        cpol_i,
    input  wire        cpha_i,
    input  wire        msb_first_i,
    input  wire [31:0] miso_word_i,
    output logic       miso_o
);

    logic rec_bits [1024];  // MOSI bits in the order they were sampled
    int   rec_cnt;
    int   tx_idx;
    logic sck_prev;
    logic csn_prev;

    function automatic logic wire_bit(input int k);
        if (k >= 32) begin
            return 1'b0;
        end
        return msb_first_i ? miso_word_i[31-k] : miso_word_i[k];
    endfunction

    initial begin
        rec_cnt  = 0;
        tx_idx   = 0;
        miso_o   = 1'b0;
        sck_prev = 1'b0;
        csn_prev = 1'b1;
    end

    always @(posedge sck_i or negedge sck_i or posedge csn_i or negedge csn_i) begin
        if (csn_i != csn_prev) begin
            csn_prev = csn_i;
            if (csn_i == 1'b0) begin
                tx_idx = 0;
                if (!cpha_i) begin
                    miso_o = wire_bit(0);   // First bit is on the wire before any edge
                    tx_idx = 1;
                end
            end
        end
        if (sck_i != sck_prev) begin
            sck_prev = sck_i;
            if (csn_i == 1'b0) begin
                if (sck_i == (cpol_i == cpha_i)) begin
                    if (rec_cnt < 1024) begin
                        rec_bits[rec_cnt] = mosi_i;
                    end
                    rec_cnt = rec_cnt + 1;
                end else begin
                    miso_o = wire_bit(tx_idx);
                    tx_idx = tx_idx + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/spi_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_ctrl_top (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        bus_req_i,
    input  logic        bus_we_i,
    input  logic [1:0]  bus_addr_i,
    input  logic [31:0] bus_wdata_i,
    output logic [31:0] bus_rdata_o,
    output logic        bus_rvalid_o,
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    output logic        spi_csn_o,
    input  logic        spi_miso_i
);

    logic                                cmd_push;
    logic [32+`SPI_TXN_SIZE-1:0]         cmd_push_data;
    logic [32+`SPI_TXN_SIZE-1:0]         cmd_pop_data;
    logic                                cmd_pop;
    logic                                cmd_full;
    logic                                cmd_empty;
    logic                                rsp_push;
    logic [`SPI_TXN_SIZE-1:0]            rsp_push_data;
    logic                                rsp_pop;
    logic [`SPI_TXN_SIZE-1:0]            rsp_pop_data;
    logic                                rsp_empty;
    logic [$clog2(`SPI_RSP_DEPTH+1)-1:0] rsp_level;
    logic                                busy;

    spi_cmd_if cmd_if ();

    assign cmd_if.ctrl  = cmd_pop_data[32+`SPI_TXN_SIZE-1 -: 32];
    assign cmd_if.data  = cmd_pop_data[`SPI_TXN_SIZE-1:0];
    assign cmd_if.valid = !cmd_empty;
    assign cmd_pop      = cmd_if.valid && cmd_if.ready;

    spi_regs u_regs (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .bus_req_i       (bus_req_i),
        .bus_we_i        (bus_we_i),
        .bus_addr_i      (bus_addr_i),
        .bus_wdata_i     (bus_wdata_i),
        .bus_rdata_o     (bus_rdata_o),
        .bus_rvalid_o    (bus_rvalid_o),
        .cmd_push_o      (cmd_push),
        .cmd_push_data_o (cmd_push_data),
        .cmd_full_i      (cmd_full),
        .rsp_pop_o       (rsp_pop),
        .rsp_data_i      (rsp_pop_data),
        .rsp_empty_i     (rsp_empty),
        .rsp_level_i     (rsp_level),
        .busy_i          (busy)
    );

    spi_fifo #(.WIDTH(32 + `SPI_TXN_SIZE), .DEPTH(`SPI_CMD_DEPTH)) u_cmd_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (cmd_push),
        .push_data_i (cmd_push_data),
        .pop_i       (cmd_pop),
        .pop_data_o  (cmd_pop_data),
        .full_o      (cmd_full),
        .empty_o     (cmd_empty),
        .level_o     ()
    );

    spi_fifo #(.WIDTH(`SPI_TXN_SIZE), .DEPTH(`SPI_RSP_DEPTH)) u_rsp_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .push_i      (rsp_push),
        .push_data_i (rsp_push_data),
        .pop_i       (rsp_pop),
        .pop_data_o  (rsp_pop_data),
        .full_o      (),
        .empty_o     (rsp_empty),
        .level_o     (rsp_level)
    );

    spi_shift_engine u_engine (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cmd        (cmd_if),
        .miso_i     (spi_miso_i),
        .mosi_o     (spi_mosi_o),
        .csn_o      (spi_csn_o),
        .sck_o      (spi_sck_o),
        .rsp_push_o (rsp_push),
        .rsp_data_o (rsp_push_data),
        .busy_o     (busy)
    );

endmodule

`default_nettype wire

// File: hw/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_regs (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    input  logic                                 bus_req_i,
    input  logic                                 bus_we_i,
    input  logic [1:0]                           bus_addr_i,
    input  logic [31:0]                          bus_wdata_i,
    output logic [31:0]                          bus_rdata_o,
    output logic                                 bus_rvalid_o,
    output logic                                 cmd_push_o,
    output logic [32+`SPI_TXN_SIZE-1:0]          cmd_push_data_o,
    input  logic                                 cmd_full_i,
    output logic                                 rsp_pop_o,
    input  logic [`SPI_TXN_SIZE-1:0]             rsp_data_i,
    input  logic                                 rsp_empty_i,
    input  logic [$clog2(`SPI_RSP_DEPTH+1)-1:0]  rsp_level_i,
    input  logic                                 busy_i
);

    localparam int LVL_W = $clog2(`SPI_RSP_DEPTH+1);

    spi_reg_pkg::spi_ctrl_word_u ctrl_q;
    logic                        wr_en;
    logic                        rd_en;
    logic [31:0]                 rd_mux;
    logic [31:0]                 rdata_q;
    logic                        rvalid_q;

    assign wr_en = bus_req_i && bus_we_i;
    assign rd_en = bus_req_i && !bus_we_i;

    // Each data word carries a snapshot of the control register
    assign cmd_push_o      = wr_en && (bus_addr_i == `SPI_REG_TXDATA) && !cmd_full_i;
    assign cmd_push_data_o = {ctrl_q.raw, bus_wdata_i[`SPI_TXN_SIZE-1:0]};

    assign rsp_pop_o = rd_en && (bus_addr_i == `SPI_REG_RXDATA) && !rsp_empty_i;

    always_comb begin
        rd_mux = '0;
        case (bus_addr_i)
            `SPI_REG_CTRL: begin
                rd_mux = ctrl_q.raw;
            end
            `SPI_REG_RXDATA: begin
                if (!rsp_empty_i) begin
                    rd_mux = 32'(rsp_data_i);
                end
            end
            `SPI_REG_STATUS: begin
                rd_mux[0]           = cmd_full_i;
                rd_mux[1]           = rsp_empty_i;
                rd_mux[2]           = busy_i;
                rd_mux[8 +: LVL_W]  = rsp_level_i;
            end
            default: begin
                rd_mux = '0;   // TXDATA is write only
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ctrl_q.raw <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
            if (wr_en && (bus_addr_i == `SPI_REG_CTRL)) begin
                ctrl_q.raw <= bus_wdata_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rd_mux;
        end
    end

    assign bus_rdata_o  = rdata_q;
    assign bus_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: hw/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_shift_engine (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    spi_cmd_if.dst                   cmd,
    input  logic                     miso_i,
    output logic                     mosi_o,
    output logic                     csn_o,
    output logic                     sck_o,
    output logic                     rsp_push_o,
    output logic [`SPI_TXN_SIZE-1:0] rsp_data_o,
    output logic                     busy_o
);

    localparam int IDX_W = $clog2(`SPI_TXN_SIZE);
    localparam logic [IDX_W:0] NBITS = (IDX_W+1)'(`SPI_TXN_SIZE);
    localparam logic [6:0]     NEDGES = 7'(2 * `SPI_TXN_SIZE);

    spi_xfer_pkg::spi_state_e       state_q;
    spi_reg_pkg::spi_ctrl_word_u    cmd_word;
    spi_reg_pkg::spi_ctrl_word_u    ctrl_q;
    logic [`SPI_TXN_SIZE-1:0]       tx_q;
    logic [`SPI_TXN_SIZE-1:0]       rx_q;
    logic [IDX_W:0]                 bit_idx_q;
    logic                           mosi_q;
    logic                           csn_q;
    logic                           rsp_push_q;
    logic                           sck_en;
    logic                           sample;
    logic                           shift;
    logic [6:0]                     edge_cnt;
    logic                           xfer_done;
    logic                           cmd_take;
    logic                           tx_step;
    logic                           rx_step;

    function automatic logic [`SPI_TXN_SIZE-1:0] bit_rev(input logic [`SPI_TXN_SIZE-1:0] d);
        logic [`SPI_TXN_SIZE-1:0] r;
        for (int i = 0; i < `SPI_TXN_SIZE; i++) begin
            r[i] = d[`SPI_TXN_SIZE-1-i];
        end
        return r;
    endfunction

    always_comb cmd_word.raw = cmd.ctrl;

    assign cmd.ready = (state_q == spi_xfer_pkg::ST_IDLE);
    assign cmd_take  = cmd.ready && cmd.valid;
    assign xfer_done = (edge_cnt == NEDGES);
    assign tx_step   = (state_q == spi_xfer_pkg::ST_SEND) && shift && (bit_idx_q < NBITS);
    assign rx_step   = (state_q == spi_xfer_pkg::ST_RECV) && sample && (bit_idx_q < NBITS);
    // Clock stops on the cycle the last edge is seen
    assign sck_en    = ((state_q == spi_xfer_pkg::ST_SEND) ||
                        (state_q == spi_xfer_pkg::ST_RECV)) && !xfer_done;

    spi_sck_gen u_sck_gen (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .enable_i   (sck_en),
        .cpol_i     (ctrl_q.f.cpol),
        .cpha_i     (ctrl_q.f.cpha),
        .div_i      (ctrl_q.f.sck_div),
        .sck_o      (sck_o),
        .sample_o   (sample),
        .shift_o    (shift),
        .edge_cnt_o (edge_cnt)
    );

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= spi_xfer_pkg::ST_IDLE;
            ctrl_q.raw <= '0;
            bit_idx_q  <= '0;
            mosi_q     <= 1'b0;
            csn_q      <= 1'b1;
            rsp_push_q <= 1'b0;
        end else begin
            rsp_push_q <= 1'b0;
            case (state_q)
                spi_xfer_pkg::ST_IDLE: begin
                    if (cmd_take) begin
                        ctrl_q  <= cmd_word;
                        state_q <= spi_xfer_pkg::ST_START;
                    end
                end
                spi_xfer_pkg::ST_START: begin
                    bit_idx_q <= '0;
                    if (ctrl_q.f.dir != spi_xfer_pkg::DIR_NONE) begin
                        csn_q <= 1'b0;
                    end
                    if ((ctrl_q.f.dir & spi_xfer_pkg::DIR_TX) != 2'b00) begin
                        state_q <= spi_xfer_pkg::ST_SEND;
                        if (!ctrl_q.f.cpha) begin
                            mosi_q    <= tx_q[0];   // First bit goes out before the first edge
                            bit_idx_q <= (IDX_W+1)'(1);
                        end
                    end else if (ctrl_q.f.dir == spi_xfer_pkg::DIR_RX) begin
                        state_q <= spi_xfer_pkg::ST_RECV;
                    end else begin
                        state_q <= spi_xfer_pkg::ST_IDLE;
                    end
                end
                spi_xfer_pkg::ST_SEND: begin
                    if (tx_step) begin
                        mosi_q    <= tx_q[bit_idx_q[IDX_W-1:0]];
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                    if (xfer_done) begin
                        csn_q   <= ctrl_q.f.end_cs;
                        state_q <= spi_xfer_pkg::ST_IDLE;
                    end
                end
                default: begin
                    if (rx_step) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                    if (xfer_done) begin
                        csn_q      <= ctrl_q.f.end_cs;
                        rsp_push_q <= 1'b1;
                        state_q    <= spi_xfer_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_take) begin
            tx_q <= cmd_word.f.msb_first ? bit_rev(cmd.data) : cmd.data;
        end
        if (rx_step) begin
            rx_q[bit_idx_q[IDX_W-1:0]] <= miso_i;
        end
    end

    assign mosi_o     = mosi_q;
    assign csn_o      = csn_q;
    assign rsp_push_o = rsp_push_q;
    assign rsp_data_o = ctrl_q.f.msb_first ? bit_rev(rx_q) : rx_q;
    assign busy_o     = (state_q != spi_xfer_pkg::ST_IDLE) || cmd.valid;

endmodule

`default_nettype wire

// File: hw/spi_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sck_gen (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        enable_i,
    input  logic        cpol_i,
    input  logic        cpha_i,
    input  logic [15:0] div_i,
    output logic        sck_o,
    output logic        sample_o,
    output logic        shift_o,
    output logic [6:0]  edge_cnt_o
);

    logic [15:0] cnt_q;
    logic [15:0] half;
    logic        toggle;
    logic        sck_q;
    logic        rise_q;
    logic        fall_q;
    logic [6:0]  edge_q;

    assign half   = {1'b0, div_i[15:1]};
    assign toggle = enable_i && (cnt_q == half - 16'd1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q  <= '0;
            sck_q  <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            edge_q <= '0;
        end else if (!enable_i) begin
            cnt_q  <= '0;
            sck_q  <= cpol_i;      // Idle level follows the clock polarity
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            edge_q <= '0;
        end else begin
            cnt_q  <= toggle ? '0 : cnt_q + 16'd1;
            rise_q <= toggle && !sck_q;
            fall_q <= toggle && sck_q;
            if (toggle) begin
                sck_q  <= !sck_q;
                edge_q <= edge_q + 7'd1;
            end
        end
    end

    // Modes 1 and 2 sample on the falling edge
    assign sample_o = (cpol_i ^ cpha_i) ? fall_q : rise_q;
    assign shift_o  = (cpol_i ^ cpha_i) ? rise_q : fall_q;

    assign sck_o      = sck_q;
    assign edge_cnt_o = edge_q;

endmodule

`default_nettype wire

// File: hw/spi_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       push_i,
    input  logic [WIDTH-1:0]           push_data_i,
    input  logic                       pop_i,
    output logic [WIDTH-1:0]           pop_data_o,
    output logic                       full_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] level_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(DEPTH+1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [LW-1:0]    level_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (level_q == LW'(DEPTH));
    assign empty_o = (level_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                level_q <= level_q + 1'b1;
            end else if (do_pop && !do_push) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign pop_data_o = mem_q[rd_ptr_q];   // Oldest entry shows while not empty
    assign level_o    = level_q;

endmodule

`default_nettype wire

// File: hw/spi_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

interface spi_cmd_if;

    logic [31:0]              ctrl;    // Raw control word captured with the data
    logic [`SPI_TXN_SIZE-1:0] data;
    logic                     valid;
    logic                     ready;

    modport src (
        output ctrl,
        output data,
        output valid,
        input  ready
    );

    modport dst (
        input  ctrl,
        input  data,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/spi_xfer_pkg.sv
`default_nettype none

package spi_xfer_pkg;

    // Bit 1 set means TX, so code 3 also sends
    localparam logic [1:0] DIR_NONE = 2'd0;
    localparam logic [1:0] DIR_RX   = 2'd1;
    localparam logic [1:0] DIR_TX   = 2'd2;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_START = 2'd1,
        ST_SEND  = 2'd2,
        ST_RECV  = 2'd3
    } spi_state_e;

endpackage

`default_nettype wire

// File: hw/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

    // Field layout of the control register, MSB first
    typedef struct packed {
        logic [9:0]  rsvd;
        logic [1:0]  dir;          // Direction code from spi_xfer_pkg
        logic        end_cs;       // CSN level left after the transfer
        logic        msb_first;
        logic        cpha;
        logic        cpol;
        logic [15:0] sck_div;      // clk_i cycles per SCK period
    } spi_ctrl_fields_t;

    // Bus side sees one raw word and the engine sees the fields
    typedef union packed {
        logic [31:0]      raw;
        spi_ctrl_fields_t f;
    } spi_ctrl_word_u;

endpackage

`default_nettype wire

// File: hw/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Bits shifted per transfer
`define SPI_TXN_SIZE 32

`define SPI_CMD_DEPTH 4
`define SPI_RSP_DEPTH 4

// Word offsets on the 2-bit register address
`define SPI_REG_CTRL   2'd0
`define SPI_REG_TXDATA 2'd1
`define SPI_REG_RXDATA 2'd2
`define SPI_REG_STATUS 2'd3

`endif
